/* Bender.yml */
package:
  name: debug_predictor

sources:
  - source/debug_pred_pkg.sv
  - source/retire_classifier.sv
  - source/dpc_capture.sv
  - source/debug_cause_tracker.sv
  - source/debug_predictor_top.sv

  - target: simulation
    files:
      - verification/debug_predictor_props.sv
      - verification/tb_debug_predictor.sv

/* sim.f */
source/debug_pred_pkg.sv
source/retire_classifier.sv
source/dpc_capture.sv
source/debug_cause_tracker.sv
source/debug_predictor_top.sv
verification/debug_predictor_props.sv
verification/tb_debug_predictor.sv

/* source/debug_cause_tracker.sv */
// ----------------------------------------------------------
// Debug cause tracker
// Keeps the highest priority pending debug cause, follows
// the WFI sleep state and detects the first instruction
// that retires after debug code has started decoding
// ----------------------------------------------------------

`timescale 1ns/1ns

module debug_cause_tracker (
  input  logic                          cov_assert_if,
  input  logic                          rst_i,
  input  logic                          ret_valid_i,
  input  logic                          ret_trig_i,
  input  debug_pred_pkg::instr_class_e  ret_class_i,
  input  logic                          debug_mode_i,
  input  logic                          debug_req_i,
  input  logic                          dcsr_step_i,
  input  logic                          dcsr_ebreakm_i,
  input  logic                          pending_irq_i,
  input  logic                          id_valid_i,
  output debug_pred_pkg::debug_cause_e  cause_o,
  output logic                          started_dbg_o,
  output logic                          in_wfi_o,
  output logic                          first_debug_ins_o
);

  debug_pred_pkg::debug_cause_e cause_q;
  logic                         started_dbg_q;
  logic                         retired_dbg_q;
  logic                         in_wfi_q;
  logic                         ebreak_ret;
  logic                         wfi_ret;

  assign ebreak_ret = ret_valid_i
                   && ((ret_class_i == debug_pred_pkg::CLS_EBREAK)
                    || (ret_class_i == debug_pred_pkg::CLS_CEBREAK));

  assign wfi_ret = ret_valid_i && (ret_class_i == debug_pred_pkg::CLS_WFI);

  // ----------------------------------------------------------
  // Cause priority, frozen while in debug mode
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      cause_q <= debug_pred_pkg::CAUSE_NONE;
    end else if (!debug_mode_i) begin
      if (ret_valid_i && ret_trig_i) begin
        cause_q <= debug_pred_pkg::CAUSE_TRIGGER;
      end else if (ebreak_ret && dcsr_ebreakm_i) begin
        cause_q <= debug_pred_pkg::CAUSE_EBREAK;
      end else if (debug_req_i) begin
        cause_q <= debug_pred_pkg::CAUSE_HALTREQ;
      end else if (dcsr_step_i && ((cause_q == debug_pred_pkg::CAUSE_NONE)
                                || (cause_q == debug_pred_pkg::CAUSE_STEP))) begin
        // Step does not override a cause that is already pending
        cause_q <= debug_pred_pkg::CAUSE_STEP;
      end else begin
        cause_q <= debug_pred_pkg::CAUSE_NONE;
      end
    end
  end

  // ----------------------------------------------------------
  // WFI sleep state
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      in_wfi_q <= 1'b0;
    end else if (pending_irq_i || debug_req_i) begin
      // Wake-up wins over a WFI retiring in the same cycle
      in_wfi_q <= 1'b0;
    end else if (wfi_ret && !debug_mode_i && !dcsr_step_i) begin
      in_wfi_q <= 1'b1;
    end
  end

  // Decode and retirement flags for the current debug-mode stay
  always_ff @(posedge cov_assert_if) begin
    if (rst_i || !debug_mode_i) begin
      started_dbg_q <= 1'b0;
      retired_dbg_q <= 1'b0;
    end else begin
      if (id_valid_i) begin
        started_dbg_q <= 1'b1;
      end
      if (ret_valid_i) begin
        retired_dbg_q <= 1'b1;
      end
    end
  end

  assign cause_o           = cause_q;
  assign started_dbg_o     = started_dbg_q;
  assign in_wfi_o          = in_wfi_q;
  assign first_debug_ins_o = debug_mode_i && ret_valid_i && started_dbg_q && !retired_dbg_q;

endmodule

/* source/debug_pred_pkg.sv */
// ----------------------------------------------------------
// Debug predictor package
// Shared widths, RISC-V opcode words and the instruction
// class and debug cause encodings used by the predictor
// ----------------------------------------------------------

package debug_pred_pkg;

  // Default program counter width, also used for tdata2
  localparam int PC_WIDTH = 32;

  // Instruction words are always full 32-bit words
  localparam int INSTR_WIDTH = 32;

  // ----------------------------------------------------------
  // Opcode words, compared against the whole instruction
  // ----------------------------------------------------------
  localparam logic [INSTR_WIDTH-1:0] EBREAK_OPCODE  = 32'h0010_0073;
  // Compressed encoding sits in the low half
  localparam logic [INSTR_WIDTH-1:0] CEBREAK_OPCODE = 32'h0000_9002;
  localparam logic [INSTR_WIDTH-1:0] WFI_OPCODE     = 32'h1050_0073;
  localparam logic [INSTR_WIDTH-1:0] DRET_OPCODE    = 32'h7b20_0073;

  // Class of a retired instruction
  typedef enum logic [2:0] {
    CLS_OTHER   = 3'd0,
    CLS_EBREAK  = 3'd1,
    CLS_CEBREAK = 3'd2,
    CLS_WFI     = 3'd3,
    CLS_DRET    = 3'd4
  } instr_class_e;

  // Debug cause, same values as dcsr.cause
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } debug_cause_e;

endpackage

/* source/debug_predictor_top.sv */
// ----------------------------------------------------------
// Debug-entry predictor top level
// Retire classifier feeds the cause tracker and the dpc
// snapshot store, which uses the tracked cause
// ----------------------------------------------------------

`timescale 1ns/1ns

module debug_predictor_top #(
  parameter int PC_W = debug_pred_pkg::PC_WIDTH
) (
  input  logic                                    cov_assert_if,
  input  logic                                    rst_i,
  // Writeback stage
  input  logic                                    wb_valid_i,
  input  logic                                    wb_err_i,
  input  logic [debug_pred_pkg::INSTR_WIDTH-1:0]  wb_instr_i,
  input  logic [PC_W-1:0]                         wb_pc_i,
  input  logic [PC_W-1:0]                         wb_next_pc_i,
  // Trigger
  input  logic                                    trigger_en_i,
  input  logic [PC_W-1:0]                         tdata2_i,
  // Debug and core state
  input  logic                                    debug_mode_i,
  input  logic                                    debug_req_i,
  input  logic                                    dcsr_step_i,
  input  logic                                    dcsr_ebreakm_i,
  input  logic                                    pending_irq_i,
  input  logic                                    id_valid_i,
  // Predictions
  output logic                                    retire_valid_o,
  output debug_pred_pkg::instr_class_e            retire_class_o,
  output debug_pred_pkg::debug_cause_e            cause_o,
  output logic [PC_W-1:0]                         dpc_pred_o,
  output logic [PC_W-1:0]                         ebreak_pc_o,
  output logic                                    in_wfi_o,
  output logic                                    first_debug_ins_o
);

  logic [PC_W-1:0] ret_pc;
  logic [PC_W-1:0] ret_next_pc;
  logic            ret_trig;
  logic            started_dbg;

  retire_classifier #(
    .PC_W (PC_W)
  ) u_classifier (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .wb_valid_i    (wb_valid_i),
    .wb_err_i      (wb_err_i),
    .trigger_en_i  (trigger_en_i),
    .wb_instr_i    (wb_instr_i),
    .wb_pc_i       (wb_pc_i),
    .wb_next_pc_i  (wb_next_pc_i),
    .tdata2_i      (tdata2_i),
    .ret_valid_o   (retire_valid_o),
    .ret_class_o   (retire_class_o),
    .ret_pc_o      (ret_pc),
    .ret_next_pc_o (ret_next_pc),
    .ret_trig_o    (ret_trig)
  );

  debug_cause_tracker u_tracker (
    .cov_assert_if     (cov_assert_if),
    .rst_i             (rst_i),
    .ret_valid_i       (retire_valid_o),
    .ret_trig_i        (ret_trig),
    .ret_class_i       (retire_class_o),
    .debug_mode_i      (debug_mode_i),
    .debug_req_i       (debug_req_i),
    .dcsr_step_i       (dcsr_step_i),
    .dcsr_ebreakm_i    (dcsr_ebreakm_i),
    .pending_irq_i     (pending_irq_i),
    .id_valid_i        (id_valid_i),
    .cause_o           (cause_o),
    .started_dbg_o     (started_dbg),
    .in_wfi_o          (in_wfi_o),
    .first_debug_ins_o (first_debug_ins_o)
  );

  dpc_capture #(
    .PC_W (PC_W)
  ) u_dpc_capture (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .ret_valid_i   (retire_valid_o),
    .ret_trig_i    (ret_trig),
    .ret_class_i   (retire_class_o),
    .ret_pc_i      (ret_pc),
    .ret_next_pc_i (ret_next_pc),
    .cause_i       (cause_o),
    .debug_mode_i  (debug_mode_i),
    .started_dbg_i (started_dbg),
    .dpc_pred_o    (dpc_pred_o),
    .ebreak_pc_o   (ebreak_pc_o)
  );

endmodule

/* source/dpc_capture.sv */
// ----------------------------------------------------------
// dpc and ebreak PC snapshot store
// Tracks the address expected in dpc on debug entry and the
// PC of the most recent ebreak or c.ebreak retirement
// ----------------------------------------------------------

`timescale 1ns/1ns

module dpc_capture #(
  parameter int PC_W = 32
) (
  input  logic                          cov_assert_if,
  input  logic                          rst_i,
  input  logic                          ret_valid_i,
  input  logic                          ret_trig_i,
  input  debug_pred_pkg::instr_class_e  ret_class_i,
  input  logic [PC_W-1:0]               ret_pc_i,
  input  logic [PC_W-1:0]               ret_next_pc_i,
  input  debug_pred_pkg::debug_cause_e  cause_i,
  input  logic                          debug_mode_i,
  input  logic                          started_dbg_i,
  output logic [PC_W-1:0]               dpc_pred_o,
  output logic [PC_W-1:0]               ebreak_pc_o
);

  logic            dpc_frozen;
  logic            use_cur_pc;
  logic            is_ebreak;
  logic [PC_W-1:0] dpc_sel;

  // Once debug code is being decoded, dpc must not move
  assign dpc_frozen = debug_mode_i && started_dbg_i;

  // Trigger and ebreak entries report the PC of the instruction itself
  assign use_cur_pc = ret_trig_i
                   || (((cause_i == debug_pred_pkg::CAUSE_TRIGGER)
                     || (cause_i == debug_pred_pkg::CAUSE_EBREAK))
                     && !started_dbg_i);

  assign dpc_sel = use_cur_pc ? ret_pc_i : ret_next_pc_i;

  assign is_ebreak = (ret_class_i == debug_pred_pkg::CLS_EBREAK)
                  || (ret_class_i == debug_pred_pkg::CLS_CEBREAK);

  // ----------------------------------------------------------
  // Predicted dpc
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      dpc_pred_o <= '0;
    end else if (ret_valid_i && !dpc_frozen) begin
      dpc_pred_o <= dpc_sel;
    end
  end

  // ----------------------------------------------------------
  // Last ebreak PC
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      ebreak_pc_o <= '0;
    end else if (ret_valid_i && is_ebreak) begin
      ebreak_pc_o <= ret_pc_i;
    end
  end

endmodule

/* source/retire_classifier.sv */
// ----------------------------------------------------------
// Retire classifier
// Samples the writeback stage, classifies each error-free
// retirement as ebreak, c.ebreak, wfi, dret or other and
// flags address trigger matches, all one cycle later
// ----------------------------------------------------------

`timescale 1ns/1ns

module retire_classifier #(
  parameter int PC_W = 32
) (
  input  logic                                       cov_assert_if,
  input  logic                                       rst_i,
  input  logic                                       wb_valid_i,
  input  logic                                       wb_err_i,
  input  logic                                       trigger_en_i,
  input  logic [debug_pred_pkg::INSTR_WIDTH-1:0]     wb_instr_i,
  input  logic [PC_W-1:0]                            wb_pc_i,
  input  logic [PC_W-1:0]                            wb_next_pc_i,
  input  logic [PC_W-1:0]                            tdata2_i,
  output logic                                       ret_valid_o,
  output debug_pred_pkg::instr_class_e               ret_class_o,
  output logic [PC_W-1:0]                            ret_pc_o,
  output logic [PC_W-1:0]                            ret_next_pc_o,
  output logic                                       ret_trig_o
);

  debug_pred_pkg::instr_class_e class_d;
  logic                         retire_ok;
  logic                         trig_d;

  // A retirement only counts when it completes without error
  assign retire_ok = wb_valid_i && !wb_err_i;

  // Address match on the retiring PC, gated by the trigger enable
  assign trig_d = retire_ok && trigger_en_i && (wb_pc_i == tdata2_i);

  // Opcode decode on the full instruction word
  always_comb begin
    case (wb_instr_i)
      debug_pred_pkg::EBREAK_OPCODE:  class_d = debug_pred_pkg::CLS_EBREAK;
      debug_pred_pkg::CEBREAK_OPCODE: class_d = debug_pred_pkg::CLS_CEBREAK;
      debug_pred_pkg::WFI_OPCODE:     class_d = debug_pred_pkg::CLS_WFI;
      debug_pred_pkg::DRET_OPCODE:    class_d = debug_pred_pkg::CLS_DRET;
      default:                        class_d = debug_pred_pkg::CLS_OTHER;
    endcase
  end

  // ----------------------------------------------------------
  // Retirement strobe, class and trigger flag
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      ret_valid_o <= 1'b0;
      ret_class_o <= debug_pred_pkg::CLS_OTHER;
      ret_trig_o  <= 1'b0;
    end else begin
      ret_valid_o <= retire_ok;
      ret_class_o <= class_d;
      ret_trig_o  <= trig_d;
    end
  end

  // PCs of the retiring instruction and its successor
  always_ff @(posedge cov_assert_if) begin
    ret_pc_o      <= wb_pc_i;
    ret_next_pc_o <= wb_next_pc_i;
  end

endmodule

/* verification/debug_predictor_props.sv */
// ----------------------------------------------------------
// Debug cause tracker properties
// Concurrent checks on the cause, WFI and first debug
// instruction outputs, bound into the cause tracker
// ----------------------------------------------------------

`timescale 1ns/1ns

module debug_predictor_props (
  input  logic                          cov_assert_if,
  input  logic                          rst_i,
  input  logic                          debug_mode_i,
  input  debug_pred_pkg::debug_cause_e  cause_i,
  input  logic                          in_wfi_i,
  input  logic                          first_debug_ins_i
);

  int fail_count = 0;

  // Cause is frozen for the whole debug-mode stay
  cause_stable_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    ($past(debug_mode_i) && !$past(rst_i)) |-> $stable(cause_i)
  ) else begin
    fail_count++;
    $error("cause changed while the core was in debug mode");
  end

  // WFI sleep is only entered from normal execution
  wfi_no_rise_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    $rose(in_wfi_i) |-> !$past(debug_mode_i)
  ) else begin
    fail_count++;
    $error("in_wfi rose while the core was in debug mode");
  end

  // Single-cycle pulse
  first_debug_single: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    first_debug_ins_i |=> !first_debug_ins_i
  ) else begin
    fail_count++;
    $error("first_debug_ins stayed high for two cycles");
  end

endmodule

bind debug_cause_tracker debug_predictor_props u_props (
  .cov_assert_if     (cov_assert_if),
  .rst_i             (rst_i),
  .debug_mode_i      (debug_mode_i),
  .cause_i           (cause_o),
  .in_wfi_i          (in_wfi_o),
  .first_debug_ins_i (first_debug_ins_o)
);

/* verification/tb_debug_predictor.sv */
// ----------------------------------------------------------
// Debug-entry predictor testbench
// Random writeback and debug stimulus from an LFSR, checked
// every cycle against a two-stage reference model
// ----------------------------------------------------------

`timescale 1ns/1ns

module tb_debug_predictor;

  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 200;

  logic        clk;
  logic        rst_i;
  logic        wb_valid, wb_err, trigger_en;
  logic [31:0] wb_instr, wb_pc, wb_next_pc, tdata2;
  logic        debug_mode, debug_req, dcsr_step, dcsr_ebreakm;
  logic        pending_irq, id_valid;

  logic                         retire_valid;
  debug_pred_pkg::instr_class_e retire_class;
  debug_pred_pkg::debug_cause_e cause;
  logic [31:0]                  dpc_pred, ebreak_pc;
  logic                         in_wfi, first_debug_ins;

  // Reference model state
  logic                         m_ret_valid, m_ret_trig;
  debug_pred_pkg::instr_class_e m_ret_class;
  logic [31:0]                  m_ret_pc, m_ret_next_pc;
  debug_pred_pkg::debug_cause_e m_cause;
  logic                         m_in_wfi, m_started, m_retired;
  logic [31:0]                  m_dpc, m_ebreak_pc;
  logic                         m_first;

  logic [31:0] lfsr_state;
  int          cycle_count;
  int          stay_pulses;
  int          err_retire, err_cause, err_dpc, err_wfi, err_first, err_reset;
  int          err_props;
  int          total_errors;

  debug_predictor_top #(
    .PC_W (debug_pred_pkg::PC_WIDTH)
  ) uut (
    .cov_assert_if     (clk),
    .rst_i             (rst_i),
    .wb_valid_i        (wb_valid),
    .wb_err_i          (wb_err),
    .wb_instr_i        (wb_instr),
    .wb_pc_i           (wb_pc),
    .wb_next_pc_i      (wb_next_pc),
    .trigger_en_i      (trigger_en),
    .tdata2_i          (tdata2),
    .debug_mode_i      (debug_mode),
    .debug_req_i       (debug_req),
    .dcsr_step_i       (dcsr_step),
    .dcsr_ebreakm_i    (dcsr_ebreakm),
    .pending_irq_i     (pending_irq),
    .id_valid_i        (id_valid),
    .retire_valid_o    (retire_valid),
    .retire_class_o    (retire_class),
    .cause_o           (cause),
    .dpc_pred_o        (dpc_pred),
    .ebreak_pc_o       (ebreak_pc),
    .in_wfi_o          (in_wfi),
    .first_debug_ins_o (first_debug_ins)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      val = {val[30:0], out_bit};
    end
    return val;
  endfunction

  function automatic debug_pred_pkg::instr_class_e classify(input logic [31:0] instr);
    if (instr == debug_pred_pkg::EBREAK_OPCODE) return debug_pred_pkg::CLS_EBREAK;
    if (instr == debug_pred_pkg::CEBREAK_OPCODE) return debug_pred_pkg::CLS_CEBREAK;
    if (instr == debug_pred_pkg::WFI_OPCODE) return debug_pred_pkg::CLS_WFI;
    if (instr == debug_pred_pkg::DRET_OPCODE) return debug_pred_pkg::CLS_DRET;
    return debug_pred_pkg::CLS_OTHER;
  endfunction

  task automatic drive_random_inputs();
    logic [31:0] pc;
    logic [2:0]  sel;
    pc  = take_bits(30) << 2;
    sel = 3'(take_bits(3));
    case (sel)
      3'd0:    wb_instr <= debug_pred_pkg::EBREAK_OPCODE;
      3'd1:    wb_instr <= debug_pred_pkg::CEBREAK_OPCODE;
      3'd2:    wb_instr <= debug_pred_pkg::WFI_OPCODE;
      3'd3:    wb_instr <= debug_pred_pkg::DRET_OPCODE;
      default: wb_instr <= take_bits(32);
    endcase
    wb_valid     <= (take_bits(3) < 3);
    wb_err       <= (take_bits(4) == 0);
    wb_pc        <= pc;
    wb_next_pc   <= pc + 32'd4;
    trigger_en   <= 1'(take_bits(1));
    // Trigger address hits the retiring PC now and then
    tdata2       <= (take_bits(2) == 0) ? pc : take_bits(32);
    dcsr_step    <= (take_bits(3) == 0);
    dcsr_ebreakm <= (take_bits(2) == 0);
    debug_req    <= (take_bits(5) == 0);
    pending_irq  <= (take_bits(4) == 0);
    id_valid     <= (take_bits(2) == 0);
    if (take_bits(6) == 0) begin
      debug_mode <= !debug_mode;
    end
  endtask

  // ----------------------------------------------------------
  // Reference model, two stages like the writeback path
  // ----------------------------------------------------------
  always @(posedge clk) begin : model_update
    logic ebreak_ret;
    logic wfi_ret;
    logic use_pc;
    if (rst_i) begin
      m_cause     = debug_pred_pkg::CAUSE_NONE;
      m_in_wfi    = 1'b0;
      m_started   = 1'b0;
      m_retired   = 1'b0;
      m_dpc       = '0;
      m_ebreak_pc = '0;
      m_ret_valid = 1'b0;
      m_ret_class = debug_pred_pkg::CLS_OTHER;
      m_ret_trig  = 1'b0;
    end else begin
      ebreak_ret = m_ret_valid && ((m_ret_class == debug_pred_pkg::CLS_EBREAK)
                                || (m_ret_class == debug_pred_pkg::CLS_CEBREAK));
      wfi_ret    = m_ret_valid && (m_ret_class == debug_pred_pkg::CLS_WFI);
      // Second stage reads the old cause and started flag
      if (m_ret_valid && !(debug_mode && m_started)) begin
        use_pc = m_ret_trig || (!m_started && ((m_cause == debug_pred_pkg::CAUSE_TRIGGER)
                                           || (m_cause == debug_pred_pkg::CAUSE_EBREAK)));
        m_dpc  = use_pc ? m_ret_pc : m_ret_next_pc;
      end
      if (ebreak_ret) begin
        m_ebreak_pc = m_ret_pc;
      end
      if (!debug_mode) begin
        if (m_ret_valid && m_ret_trig) begin
          m_cause = debug_pred_pkg::CAUSE_TRIGGER;
        end else if (ebreak_ret && dcsr_ebreakm) begin
          m_cause = debug_pred_pkg::CAUSE_EBREAK;
        end else if (debug_req) begin
          m_cause = debug_pred_pkg::CAUSE_HALTREQ;
        end else if (dcsr_step && ((m_cause == debug_pred_pkg::CAUSE_NONE)
                                || (m_cause == debug_pred_pkg::CAUSE_STEP))) begin
          m_cause = debug_pred_pkg::CAUSE_STEP;
        end else begin
          m_cause = debug_pred_pkg::CAUSE_NONE;
        end
      end
      if (pending_irq || debug_req) begin
        m_in_wfi = 1'b0;
      end else if (wfi_ret && !debug_mode && !dcsr_step) begin
        m_in_wfi = 1'b1;
      end
      if (!debug_mode) begin
        m_started = 1'b0;
        m_retired = 1'b0;
      end else begin
        m_started = m_started || id_valid;
        m_retired = m_retired || m_ret_valid;
      end
      m_ret_valid = wb_valid && !wb_err;
      m_ret_class = classify(wb_instr);
      m_ret_trig  = wb_valid && !wb_err && trigger_en && (wb_pc == tdata2);
    end
    m_ret_pc      = wb_pc;
    m_ret_next_pc = wb_next_pc;
  end

  task automatic check_reset_values();
    assert (!retire_valid && !in_wfi && !first_debug_ins
            && (cause == debug_pred_pkg::CAUSE_NONE)
            && (dpc_pred == '0) && (ebreak_pc == '0)) else begin
      err_reset++;
      $display("error %0t: outputs not at reset values", $time);
    end
  endtask

  task automatic check_outputs();
    assert (retire_valid == m_ret_valid) else begin
      err_retire++;
      $display("error %0t: retire_valid %0b, expected %0b", $time, retire_valid, m_ret_valid);
    end
    if (m_ret_valid) begin
      assert (retire_class == m_ret_class) else begin
        err_retire++;
        $display("error %0t: retire_class %0d, expected %0d", $time, retire_class, m_ret_class);
      end
    end
    assert (cause == m_cause) else begin
      err_cause++;
      $display("error %0t: cause %0d, expected %0d", $time, cause, m_cause);
    end
    assert ((dpc_pred == m_dpc) && (ebreak_pc == m_ebreak_pc)) else begin
      err_dpc++;
      $display("error %0t: dpc %h ebreak_pc %h, expected %h %h",
               $time, dpc_pred, ebreak_pc, m_dpc, m_ebreak_pc);
    end
    assert (in_wfi == m_in_wfi) else begin
      err_wfi++;
      $display("error %0t: in_wfi %0b, expected %0b", $time, in_wfi, m_in_wfi);
    end
    assert (first_debug_ins == m_first) else begin
      err_first++;
      $display("error %0t: first_debug_ins %0b, expected %0b", $time, first_debug_ins, m_first);
    end
  endtask

  // Outputs are compared at the falling edge, away from any update
  always @(negedge clk) begin
    if (cycle_count > 0) begin
      if (rst_i) begin
        check_reset_values();
      end else begin
        m_first = debug_mode && m_ret_valid && m_started && !m_retired;
        check_outputs();
        if (!debug_mode) begin
          stay_pulses = 0;
        end else if (first_debug_ins) begin
          stay_pulses++;
          assert (stay_pulses <= 1) else begin
            err_first++;
            $display("error %0t: first_debug_ins pulsed twice in one debug stay", $time);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    lfsr_state   = 32'h8f09_901f;
    cycle_count  = 0;
    stay_pulses  = 0;
    err_retire   = 0;
    err_cause    = 0;
    err_dpc      = 0;
    err_wfi      = 0;
    err_first    = 0;
    err_reset    = 0;
    err_props    = 0;
    rst_i        = 1'b1;
    wb_valid     = 1'b0;
    wb_err       = 1'b0;
    trigger_en   = 1'b0;
    wb_instr     = '0;
    wb_pc        = '0;
    wb_next_pc   = '0;
    tdata2       = '0;
    debug_mode   = 1'b0;
    debug_req    = 1'b0;
    dcsr_step    = 1'b0;
    dcsr_ebreakm = 1'b0;
    pending_irq  = 1'b0;
    id_valid     = 1'b0;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_random_inputs();
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    // Failures of the bound properties of the cause tracker
    err_props    = uut.u_tracker.u_props.fail_count;
    total_errors = err_retire + err_cause + err_dpc + err_wfi + err_first + err_reset
                 + err_props;
    $display("errors: retire=%0d cause=%0d dpc=%0d wfi=%0d first=%0d reset=%0d prop=%0d total=%0d",
             err_retire, err_cause, err_dpc, err_wfi, err_first, err_reset, err_props,
             total_errors);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
